//--- common/coproc_pkg.sv
package coproc_pkg;

  localparam int XLEN       = 32;  // data and address width
  localparam int BIT_IDX_W  = 5;   // bit position inside one word
  localparam int WORD_OFF_W = XLEN - BIT_IDX_W;

  localparam logic [6:0] OPCODE_RMLD = 7'h0B;  // custom-0, load bit-field
  localparam logic [6:0] OPCODE_RMST = 7'h2B;  // custom-1, store bit-field

  typedef enum logic [6:0] {
    OPC_RMLD = OPCODE_RMLD,
    OPC_RMST = OPCODE_RMST
  } coproc_opcode_e;

  // funct3[2] set marks a config instruction
  typedef enum logic [2:0] {
    RMXR   = 3'b000,  // store zeros
    RMXS   = 3'b001,  // store ones
    RMCS   = 3'b010,  // store shadow register
    CASRM  = 3'b101,  // store base <- rs1
    CALRM  = 3'b110,  // load base <- rs2
    CASLRM = 3'b111   // both bases
  } bf_funct3_e;

  typedef enum logic [2:0] {
    IDLE,
    CFG,
    MEM_RD1,
    MEM_RD2,
    UPDATE,
    MEM_WR1,
    MEM_WR2,
    RETIRE
  } coproc_state_e;

  // rs1 is a plain byte address for config instructions and a bit
  // pointer for field instructions
  typedef union packed {
    logic [XLEN-1:0] byte_addr;
    struct packed {
      logic [WORD_OFF_W-1:0] word_off;  // aligned word offset from base
      logic [BIT_IDX_W-1:0]  bit_idx;   // first bit of the field
    } field;
  } bit_ptr_u;

endpackage

//--- design/coproc_addr_regs.sv
`timescale 1ns/1ps

module coproc_addr_regs (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        cfg_we,
  input  coproc_pkg::bf_funct3_e      cfg_funct3,
  input  coproc_pkg::bit_ptr_u        op_rs1,
  input  logic [coproc_pkg::XLEN-1:0] op_rs2,
  input  logic                        field_is_load,
  output logic [coproc_pkg::XLEN-1:0] field_addr
);

  logic [coproc_pkg::XLEN-1:0] ld_base_q;   // base of the load stream
  logic [coproc_pkg::XLEN-1:0] st_base_q;   // base of the store stream
  logic [coproc_pkg::XLEN-1:0] base;
  logic [coproc_pkg::XLEN-1:0] word_bytes;  // word offset in bytes

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ld_base_q <= '0;
      st_base_q <= '0;
    end else if (cfg_we) begin
      case (cfg_funct3)
        coproc_pkg::CASRM: begin
          st_base_q <= op_rs1.byte_addr;
        end
        coproc_pkg::CALRM: begin
          ld_base_q <= op_rs2;
        end
        coproc_pkg::CASLRM: begin
          st_base_q <= op_rs1.byte_addr;
          ld_base_q <= op_rs2;
        end
        default: begin
          st_base_q <= st_base_q;  // field funct3, nothing to set
        end
      endcase
    end
  end

  assign base       = field_is_load ? ld_base_q : st_base_q;
  assign word_bytes = coproc_pkg::XLEN'({op_rs1.field.word_off, 2'b00});  // offset x 4
  assign field_addr = base + word_bytes;

  // the controller may only write bases while running a config instruction
  a_cfg_we_funct3 : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cfg_we |-> cfg_funct3 inside {coproc_pkg::CASRM, coproc_pkg::CALRM, coproc_pkg::CASLRM}
  ) else $error("base write with a field funct3");

endmodule

//--- bitfield/bitfield_datapath.sv
`timescale 1ns/1ps

module bitfield_datapath (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             rd_lo_we,
  input  logic                             rd_hi_we,
  input  logic                             shadow_we,
  input  logic [coproc_pkg::XLEN-1:0]      mem_rdata,
  input  logic [coproc_pkg::BIT_IDX_W-1:0] bit_idx,
  input  logic [4:0]                       field_len_m1,
  input  coproc_pkg::bf_funct3_e           src_sel,
  output logic [coproc_pkg::XLEN-1:0]      wdata_lo,
  output logic [coproc_pkg::XLEN-1:0]      wdata_hi
);

  logic [2*coproc_pkg::XLEN-1:0] rbuf_q;      // {word A+4, word A}
  logic [coproc_pkg::XLEN-1:0]   shadow_q;
  logic [coproc_pkg::XLEN-1:0]   len_mask;    // field_len_m1+1 ones at the bottom
  logic [2*coproc_pkg::XLEN-1:0] field_mask;  // len_mask moved to bit_idx
  logic [2*coproc_pkg::XLEN-1:0] rbuf_shr;
  logic [coproc_pkg::XLEN-1:0]   field_val;
  logic [2*coproc_pkg::XLEN-1:0] src_bits;
  logic [2*coproc_pkg::XLEN-1:0] merged;

  // the low word always arrives first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rbuf_q <= '0;
    end else begin
      if (rd_lo_we) begin
        rbuf_q[coproc_pkg::XLEN-1:0] <= mem_rdata;
      end
      if (rd_hi_we) begin
        rbuf_q[2*coproc_pkg::XLEN-1:coproc_pkg::XLEN] <= mem_rdata;
      end
    end
  end

  // a length of 32 gives an all-ones mask
  assign len_mask   = {coproc_pkg::XLEN{1'b1}} >> (5'd31 - field_len_m1);
  assign field_mask = {{coproc_pkg::XLEN{1'b0}}, len_mask} << bit_idx;

  assign rbuf_shr  = rbuf_q >> bit_idx;
  assign field_val = rbuf_shr[coproc_pkg::XLEN-1:0] & len_mask;  // zero-extended field

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else if (shadow_we) begin
      shadow_q <= field_val;
    end
  end

  always_comb begin
    case (src_sel)
      coproc_pkg::RMXR: begin
        src_bits = '0;
      end
      coproc_pkg::RMXS: begin
        src_bits = '1;
      end
      coproc_pkg::RMCS: begin
        src_bits = {{coproc_pkg::XLEN{1'b0}}, shadow_q} << bit_idx;  // line up with the field
      end
      default: begin
        src_bits = '0;
      end
    endcase
  end

  // only bits under the mask change, the rest of both words is written back as read
  assign merged   = (rbuf_q & ~field_mask) | (src_bits & field_mask);
  assign wdata_lo = merged[coproc_pkg::XLEN-1:0];
  assign wdata_hi = merged[2*coproc_pkg::XLEN-1:coproc_pkg::XLEN];

endmodule

//--- design/coproc_ctrl.sv
`timescale 1ns/1ps

module coproc_ctrl #(
  parameter int ID_WIDTH = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  logic                        issue_valid,
  output logic                        issue_ready,
  input  logic [31:0]                 issue_instr,
  input  logic [ID_WIDTH-1:0]         issue_id,
  input  logic [coproc_pkg::XLEN-1:0] issue_rs1,
  input  logic [coproc_pkg::XLEN-1:0] issue_rs2,
  output logic                        issue_accept,

  input  logic                        commit_valid,
  input  logic                        commit_kill,

  output logic                        mem_valid,
  output logic [coproc_pkg::XLEN-1:0] mem_addr,
  output logic                        mem_we,
  output logic [coproc_pkg::XLEN-1:0] mem_wdata,
  output logic                        mem_last,
  output logic [ID_WIDTH-1:0]         mem_id,
  input  logic                        mem_result_valid,

  output logic                        result_valid,
  input  logic                        result_ready,
  output logic [ID_WIDTH-1:0]         result_id,

  output logic                        cfg_we,
  output coproc_pkg::bf_funct3_e      cfg_funct3,
  output coproc_pkg::bit_ptr_u        op_rs1,
  output logic [coproc_pkg::XLEN-1:0] op_rs2,
  output logic                        field_is_load,
  input  logic [coproc_pkg::XLEN-1:0] field_addr,
  output logic                        rd_lo_we,
  output logic                        rd_hi_we,
  output logic                        shadow_we,
  input  logic [coproc_pkg::XLEN-1:0] wdata_lo,
  input  logic [coproc_pkg::XLEN-1:0] wdata_hi
);

  coproc_pkg::coproc_state_e  state_q;
  coproc_pkg::coproc_state_e  state_d;
  coproc_pkg::coproc_opcode_e issue_opc;
  logic                       issue_fire;
  logic                       issue_is_cfg;   // funct3[2] of the incoming instr
  logic                       commit_q;       // sticky commit
  logic                       committed;
  logic                       result_fire;
  logic                       second_word;    // request targets A+4
  logic [ID_WIDTH-1:0]        id_q;

  assign issue_opc    = coproc_pkg::coproc_opcode_e'(issue_instr[6:0]);
  assign issue_accept = issue_opc inside {coproc_pkg::OPC_RMLD, coproc_pkg::OPC_RMST};
  assign issue_ready  = state_q == coproc_pkg::IDLE;
  assign issue_fire   = issue_valid & issue_ready & issue_accept;
  assign issue_is_cfg = issue_instr[14];

  // instruction capture, one in flight so no queue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q          <= '0;
      cfg_funct3    <= coproc_pkg::RMXR;
      op_rs1        <= '0;
      op_rs2        <= '0;
      field_is_load <= 1'b0;
    end else if (issue_fire) begin
      id_q          <= issue_id;
      cfg_funct3    <= coproc_pkg::bf_funct3_e'(issue_instr[14:12]);
      op_rs1        <= issue_rs1;
      op_rs2        <= issue_rs2;
      field_is_load <= issue_opc == coproc_pkg::OPC_RMLD;
    end
  end

  assign result_fire = result_valid & result_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_q <= 1'b0;
    end else if (commit_kill || result_fire) begin
      commit_q <= 1'b0;
    end else if (commit_valid && state_q != coproc_pkg::IDLE) begin
      commit_q <= 1'b1;
    end
  end

  assign committed = commit_q | commit_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= coproc_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    if (commit_kill && state_q != coproc_pkg::IDLE) begin
      state_d = coproc_pkg::IDLE;  // abandon the instruction
    end else begin
      case (state_q)
        coproc_pkg::IDLE: begin
          if (issue_fire) begin
            state_d = issue_is_cfg ? coproc_pkg::CFG : coproc_pkg::MEM_RD1;
          end
        end
        coproc_pkg::CFG: begin
          if (committed) state_d = coproc_pkg::RETIRE;
        end
        coproc_pkg::MEM_RD1: begin
          if (mem_result_valid) state_d = coproc_pkg::MEM_RD2;
        end
        coproc_pkg::MEM_RD2: begin
          if (mem_result_valid) state_d = coproc_pkg::UPDATE;
        end
        coproc_pkg::UPDATE: begin
          if (committed) begin
            state_d = field_is_load ? coproc_pkg::RETIRE : coproc_pkg::MEM_WR1;
          end
        end
        coproc_pkg::MEM_WR1: begin
          if (mem_result_valid) state_d = coproc_pkg::MEM_WR2;
        end
        coproc_pkg::MEM_WR2: begin
          if (mem_result_valid) state_d = coproc_pkg::RETIRE;
        end
        coproc_pkg::RETIRE: begin
          if (result_ready) state_d = coproc_pkg::IDLE;
        end
        default: begin
          state_d = coproc_pkg::IDLE;
        end
      endcase
    end
  end

  // architectural updates only once committed and not killed
  assign cfg_we    = (state_q == coproc_pkg::CFG) & committed & ~commit_kill;
  assign shadow_we = (state_q == coproc_pkg::UPDATE) & committed & field_is_load & ~commit_kill;
  assign rd_lo_we  = (state_q == coproc_pkg::MEM_RD1) & mem_result_valid;
  assign rd_hi_we  = (state_q == coproc_pkg::MEM_RD2) & mem_result_valid;

  assign mem_valid   = state_q inside {coproc_pkg::MEM_RD1, coproc_pkg::MEM_RD2,
                                       coproc_pkg::MEM_WR1, coproc_pkg::MEM_WR2};
  assign second_word = state_q inside {coproc_pkg::MEM_RD2, coproc_pkg::MEM_WR2};
  assign mem_addr    = second_word ? field_addr + coproc_pkg::XLEN'(4) : field_addr;
  assign mem_we      = state_q inside {coproc_pkg::MEM_WR1, coproc_pkg::MEM_WR2};
  assign mem_wdata   = second_word ? wdata_hi : wdata_lo;
  assign mem_last    = (state_q == coproc_pkg::MEM_RD2 && field_is_load) ||
                       state_q == coproc_pkg::MEM_WR2;  // a load ends on its reads
  assign mem_id      = id_q;

  assign result_valid = state_q == coproc_pkg::RETIRE;
  assign result_id    = id_q;

  a_mem_result_excl : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(mem_valid && result_valid)
  ) else $error("memory request and result both valid");

  // a waiting request keeps its address until the responder answers
  a_mem_addr_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_valid && !mem_result_valid && !commit_kill |=> mem_valid && $stable(mem_addr)
  ) else $error("mem_addr changed while request pending");

  // no new issue slot opens until the result handshake or a kill ends the instruction
  a_busy_not_ready : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    issue_fire || (!issue_ready && !result_fire && !commit_kill) |=> !issue_ready
  ) else $error("issue_ready high while busy");

endmodule

//--- design/coproc_top.sv
`timescale 1ns/1ps

module coproc_top #(
  parameter int ID_WIDTH = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  logic                        issue_valid,
  output logic                        issue_ready,
  input  logic [31:0]                 issue_instr,
  input  logic [ID_WIDTH-1:0]         issue_id,
  input  logic [coproc_pkg::XLEN-1:0] issue_rs1,
  input  logic [coproc_pkg::XLEN-1:0] issue_rs2,
  output logic                        issue_accept,

  input  logic                        commit_valid,
  input  logic                        commit_kill,

  output logic                        mem_valid,
  output logic [coproc_pkg::XLEN-1:0] mem_addr,
  output logic                        mem_we,
  output logic [coproc_pkg::XLEN-1:0] mem_wdata,
  output logic                        mem_last,
  output logic [ID_WIDTH-1:0]         mem_id,
  input  logic                        mem_result_valid,
  input  logic [coproc_pkg::XLEN-1:0] mem_rdata,

  output logic                        result_valid,
  input  logic                        result_ready,
  output logic [ID_WIDTH-1:0]         result_id
);

  logic                        cfg_we;
  coproc_pkg::bf_funct3_e      cfg_funct3;
  coproc_pkg::bit_ptr_u        op_rs1;
  logic [coproc_pkg::XLEN-1:0] op_rs2;
  logic                        field_is_load;
  logic [coproc_pkg::XLEN-1:0] field_addr;
  logic                        rd_lo_we;
  logic                        rd_hi_we;
  logic                        shadow_we;
  logic [coproc_pkg::XLEN-1:0] wdata_lo;
  logic [coproc_pkg::XLEN-1:0] wdata_hi;

  coproc_ctrl #(
    .ID_WIDTH (ID_WIDTH)
  ) u_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .issue_valid      (issue_valid),
    .issue_ready      (issue_ready),
    .issue_instr      (issue_instr),
    .issue_id         (issue_id),
    .issue_rs1        (issue_rs1),
    .issue_rs2        (issue_rs2),
    .issue_accept     (issue_accept),
    .commit_valid     (commit_valid),
    .commit_kill      (commit_kill),
    .mem_valid        (mem_valid),
    .mem_addr         (mem_addr),
    .mem_we           (mem_we),
    .mem_wdata        (mem_wdata),
    .mem_last         (mem_last),
    .mem_id           (mem_id),
    .mem_result_valid (mem_result_valid),
    .result_valid     (result_valid),
    .result_ready     (result_ready),
    .result_id        (result_id),
    .cfg_we           (cfg_we),
    .cfg_funct3       (cfg_funct3),
    .op_rs1           (op_rs1),
    .op_rs2           (op_rs2),
    .field_is_load    (field_is_load),
    .field_addr       (field_addr),
    .rd_lo_we         (rd_lo_we),
    .rd_hi_we         (rd_hi_we),
    .shadow_we        (shadow_we),
    .wdata_lo         (wdata_lo),
    .wdata_hi         (wdata_hi)
  );

  coproc_addr_regs u_addr_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_we        (cfg_we),
    .cfg_funct3    (cfg_funct3),
    .op_rs1        (op_rs1),
    .op_rs2        (op_rs2),
    .field_is_load (field_is_load),
    .field_addr    (field_addr)
  );

  bitfield_datapath u_datapath (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_lo_we     (rd_lo_we),
    .rd_hi_we     (rd_hi_we),
    .shadow_we    (shadow_we),
    .mem_rdata    (mem_rdata),
    .bit_idx      (op_rs1.field.bit_idx),
    .field_len_m1 (op_rs2[4:0]),
    .src_sel      (cfg_funct3),
    .wdata_lo     (wdata_lo),
    .wdata_hi     (wdata_hi)
  );

endmodule

//--- testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_i,
  output logic rst_ni
);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period
  end

  initial begin
    rst_ni = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
  end

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
  parameter int ID_WIDTH = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                issue_valid,
  input  logic                issue_ready,
  input  logic [31:0]         issue_instr,
  input  logic [ID_WIDTH-1:0] issue_id,
  input  logic [31:0]         issue_rs1,
  input  logic [31:0]         issue_rs2,
  input  logic                issue_accept,
  input  logic                commit_kill,
  input  logic                mem_valid,
  input  logic [31:0]         mem_addr,
  input  logic                mem_we,
  input  logic [31:0]         mem_wdata,
  input  logic                mem_last,
  input  logic [ID_WIDTH-1:0] mem_id,
  input  logic                mem_result_valid,
  input  logic                result_valid,
  input  logic                result_ready,
  input  logic [ID_WIDTH-1:0] result_id,
  output int                  errors
);

  logic [31:0]         mem_m [64];  // model of the responder memory
  logic [31:0]         ld_base;
  logic [31:0]         st_base;
  logic [31:0]         shadow;
  logic                busy;        // an instruction is in flight
  logic                is_cfg;
  logic                is_load;
  logic [2:0]          f3;
  logic [ID_WIDTH-1:0] id;
  logic [31:0]         rs1;
  logic [31:0]         rs2;
  logic [31:0]         addr_a;
  logic [31:0]         exp_lo;
  logic [31:0]         exp_hi;
  logic [31:0]         exp_shadow;
  logic [63:0]         words;
  logic                rv_wait;
  logic [ID_WIDTH-1:0] rv_id;
  int                  nreq;

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    errors++;
  endtask

  // field model, one bit at a time from the pointer
  task automatic predict_field();
    int len;
    int pos;
    words      = {mem_m[(addr_a + 32'd4) >> 2 & 63], mem_m[addr_a >> 2 & 63]};
    len        = int'(rs2[4:0]) + 1;
    exp_shadow = '0;
    for (int k = 0; k < len; k++) begin
      pos           = int'(rs1[4:0]) + k;
      exp_shadow[k] = words[pos];
      case (f3)
        3'b000:  words[pos] = 1'b0;
        3'b001:  words[pos] = 1'b1;
        default: words[pos] = shadow[k];
      endcase
    end
    exp_lo = words[31:0];
    exp_hi = words[63:32];
  endtask

  task automatic check_request();
    logic [31:0] a;
    logic        last;
    a    = nreq[0] ? addr_a + 32'd4 : addr_a;
    last = is_load ? (nreq == 1) : (nreq == 3);
    if (is_cfg || nreq >= (is_load ? 2 : 4)) begin
      report_mismatch("memory request not expected");
    end else begin
      if (mem_addr !== a) report_mismatch($sformatf("mem_addr %h, expected %h", mem_addr, a));
      if (mem_we !== (nreq >= 2)) report_mismatch("mem_we wrong");
      if (mem_last !== last) report_mismatch("mem_last wrong");
      if (mem_id !== id) report_mismatch("mem_id wrong");
      if (nreq >= 2) begin
        if (mem_wdata !== (nreq == 2 ? exp_lo : exp_hi)) begin
          report_mismatch($sformatf("mem_wdata %h at %h", mem_wdata, a));
        end
        mem_m[a >> 2 & 63] = nreq == 2 ? exp_lo : exp_hi;
      end
    end
    nreq++;
  endtask

  task automatic retire_instr();
    if (result_id !== id) report_mismatch("result_id wrong");
    if (nreq != (is_cfg ? 0 : (is_load ? 2 : 4))) begin
      report_mismatch($sformatf("%0d memory requests before result", nreq));
    end
    if (is_cfg) begin
      if (f3[0]) st_base = rs1;  // CASRM and CASLRM
      if (f3[1]) ld_base = rs2;  // CALRM and CASLRM
    end else if (is_load) begin
      shadow = exp_shadow;
    end
    busy = 1'b0;
  endtask

  task automatic start_instr();
    f3      = issue_instr[14:12];
    is_cfg  = issue_instr[14];
    is_load = issue_instr[6:0] == 7'h0B;
    id      = issue_id;
    rs1     = issue_rs1;
    rs2     = issue_rs2;
    addr_a  = (is_load ? ld_base : st_base) + {rs1[31:5], 2'b00};
    nreq    = 0;
    busy    = 1'b1;
    predict_field();
  endtask

  initial begin
    for (int i = 0; i < 64; i++) mem_m[i] = i * 32'h9E37_79B9 ^ 32'h5A5A_0F0F;
    errors  = 0;
    ld_base = '0;
    st_base = '0;
    shadow  = '0;
    busy    = 1'b0;
    rv_wait = 1'b0;
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (issue_valid && issue_accept !== (issue_instr[6:0] inside {7'h0B, 7'h2B})) begin
        report_mismatch("issue_accept wrong for opcode");
      end
      if (rv_wait && (!result_valid || result_id !== rv_id)) begin
        report_mismatch("result changed before handshake");
      end
      rv_wait = result_valid && !result_ready;
      rv_id   = result_id;
      if (issue_ready !== !busy) begin
        report_mismatch(busy ? "issue_ready high while busy" : "issue_ready low while idle");
      end
      if (!busy && (mem_valid || result_valid)) begin
        report_mismatch("DUT active with no instruction in flight");
      end
      if (busy && mem_valid && mem_result_valid) check_request();
      if (busy && result_valid && result_ready) retire_instr();
      else if (busy && commit_kill) busy = 1'b0;  // killed, model untouched
      if (issue_valid && issue_ready && issue_accept) start_instr();
    end
  end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  logic        clk_i;
  logic        rst_ni;
  logic        issue_valid;
  logic        issue_ready;
  logic [31:0] issue_instr;
  logic [3:0]  issue_id;
  logic [31:0] issue_rs1;
  logic [31:0] issue_rs2;
  logic        issue_accept;
  logic        commit_valid;
  logic        commit_kill;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic        mem_we;
  logic [31:0] mem_wdata;
  logic        mem_last;
  logic [3:0]  mem_id;
  logic        mem_result_valid;
  logic [31:0] mem_rdata;
  logic        result_valid;
  logic        result_ready;
  logic [3:0]  result_id;

  logic [31:0] seed = 32'd80865;
  logic [31:0] mem [64];
  int          chk_errors;
  int          tests;
  int          delay;
  logic        armed;
  bit          timed_out;

  tb_clkgen u_clkgen (.clk_i(clk_i), .rst_ni(rst_ni));

  coproc_top #(.ID_WIDTH(4)) DUT (.*);

  tb_checker #(.ID_WIDTH(4)) u_checker (.*, .errors(chk_errors));

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 8;  // low LCG bits are weak
  endfunction

  // responder answers after 0 to 3 cycles
  always @(negedge clk_i) begin
    if (mem_result_valid) begin
      mem_result_valid = 1'b0;
    end else if (mem_valid) begin
      if (!armed) begin
        delay = next_rand() % 4;
        armed = 1'b1;
      end
      if (delay == 0) begin
        mem_rdata = mem[mem_addr >> 2 & 63];
        if (mem_we) mem[mem_addr >> 2 & 63] = mem_wdata;
        mem_result_valid = 1'b1;
        armed            = 1'b0;
      end else begin
        delay--;
      end
    end else begin
      armed = 1'b0;
    end
  end

  task automatic finish_run();
    $display("tests %0d, errors %0d", tests, chk_errors);
    if (chk_errors == 0 && !timed_out) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  task automatic timeout(input string what);
    $display("timeout while waiting for %s", what);
    timed_out = 1'b1;
    finish_run();
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    $display("test %0s: %0s", name, (chk_errors == errs_before) ? "ok" : "FAIL");
  endtask

  function automatic logic [31:0] rand_ptr();
    return {27'(next_rand() % 31), 5'(next_rand())};
  endfunction

  task automatic run_instr(input logic [6:0] opc, input logic [2:0] f3, input logic [31:0] rs1,
                           input logic [31:0] rs2, input bit kill, input int bp);
    int guard;
    issue_instr = {17'h0, f3, 5'h0, opc};
    issue_id    = 4'(next_rand());
    issue_rs1   = rs1;
    issue_rs2   = rs2;
    issue_valid = 1'b1;
    guard       = 0;
    @(posedge clk_i);
    while (!(issue_ready && issue_accept)) begin
      guard++;
      if (guard > 50) timeout("issue handshake");
      @(posedge clk_i);
    end
    @(negedge clk_i);
    issue_valid = 1'b0;
    if (kill) begin
      guard = 0;
      while (!mem_valid) begin
        guard++;
        if (guard > 50) timeout("first read request");
        @(negedge clk_i);
      end
      commit_kill = 1'b1;
      @(negedge clk_i);
      commit_kill = 1'b0;
      repeat (6) @(negedge clk_i);  // checker flags any result or request here
      return;
    end
    repeat (next_rand() % 3) @(negedge clk_i);
    commit_valid = 1'b1;
    @(negedge clk_i);
    commit_valid = 1'b0;
    guard        = 0;
    while (!result_valid) begin
      guard++;
      if (guard > 200) timeout("result_valid");
      @(negedge clk_i);
    end
    repeat (bp) @(negedge clk_i);
    result_ready = 1'b1;
    @(negedge clk_i);
    result_ready = 1'b0;
  endtask

  initial begin
    int guard;
    int e0;
    logic [2:0] f3;
    issue_valid      = 0;
    issue_instr      = 0;
    issue_id         = 0;
    issue_rs1        = 0;
    issue_rs2        = 0;
    commit_valid     = 0;
    commit_kill      = 0;
    mem_result_valid = 0;
    mem_rdata        = 0;
    result_ready     = 0;
    armed            = 0;
    delay            = 0;
    tests            = 0;
    timed_out        = 0;
    for (int i = 0; i < 64; i++) mem[i] = i * 32'h9E37_79B9 ^ 32'h5A5A_0F0F;
    guard = 0;
    while (!rst_ni) begin
      guard++;
      if (guard > 50) timeout("reset release");
      @(posedge clk_i);
    end
    @(negedge clk_i);

    e0 = chk_errors;
    issue_instr = 32'h0000_0033;  // not a coprocessor opcode
    issue_valid = 1'b1;
    @(negedge clk_i);
    issue_valid = 1'b0;
    repeat (5) @(negedge clk_i);
    end_test("reset and unknown opcode", e0);

    e0 = chk_errors;
    run_instr(7'h2B, 3'b101, (next_rand() % 32) << 2, next_rand(), 0, 1);
    run_instr(7'h0B, 3'b110, next_rand(), (next_rand() % 32) << 2, 0, 0);
    run_instr(7'h2B, 3'b111, (next_rand() % 32) << 2, (next_rand() % 32) << 2, 0, 2);
    run_instr(7'h0B, 3'b000, rand_ptr(), next_rand(), 0, 0);
    run_instr(7'h2B, 3'b001, rand_ptr(), next_rand(), 0, 0);
    end_test("config bases", e0);

    e0 = chk_errors;
    for (int i = 0; i < 8; i++) begin
      run_instr(7'h0B, 3'b000, rand_ptr(), next_rand(), 0, next_rand() % 4);
      run_instr(7'h2B, 3'b010, rand_ptr(), next_rand(), 0, next_rand() % 4);
    end
    end_test("load then shadow store", e0);

    e0 = chk_errors;
    run_instr(7'h2B, 3'b001, {27'd3, 5'd0}, 32'd31, 0, 0);    // full word
    run_instr(7'h2B, 3'b000, {27'd5, 5'd31}, 32'd31, 0, 0);   // length 32 across the boundary
    run_instr(7'h2B, 3'b010, {27'd7, 5'd28}, 32'd9, 0, 0);
    for (int i = 0; i < 20; i++) begin
      f3 = 3'(next_rand() % 3);
      run_instr(7'h2B, f3, rand_ptr(), next_rand(), 0, next_rand() % 4);
    end
    end_test("random stores", e0);

    e0 = chk_errors;
    run_instr(7'h0B, 3'b000, rand_ptr(), next_rand(), 1, 0);
    run_instr(7'h2B, 3'b000, rand_ptr(), next_rand(), 1, 0);
    run_instr(7'h2B, 3'b010, rand_ptr(), next_rand(), 0, 0);
    end_test("kill during reads", e0);

    e0 = chk_errors;
    for (int i = 0; i < 4; i++) begin
      run_instr(7'h0B, 3'b000, rand_ptr(), next_rand(), 0, 5 + next_rand() % 16);
      run_instr(7'h2B, 3'b110, next_rand(), (next_rand() % 32) << 2, 0, 5 + next_rand() % 16);
    end
    end_test("result back-pressure", e0);

    finish_run();
  end

endmodule

//--- coproc_top.f
common/coproc_pkg.sv
design/coproc_addr_regs.sv
bitfield/bitfield_datapath.sv
design/coproc_ctrl.sv
design/coproc_top.sv
testbench/tb_clkgen.sv
testbench/tb_checker.sv
testbench/tb_top.sv
